//--- proc_core.f
+incdir+verilog
verilog/proc_pkg.sv
verilog/exec_if.sv
verilog/instr_decode.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/proc_sequencer.sv
verilog/proc_core.sv
sim/proc_core_assertions.sv
sim/proc_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f proc_core.f \
    --top-module proc_core_tb -o proc_core_sim

output=$(./obj_dir/proc_core_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

//--- sim/proc_core_assertions.sv
// Core protocol checks
`timescale 1ns/1ps

module proc_core_assertions (
    input logic clk,
    input logic rst,
    input logic mem_rd_req,
    input logic mem_wr_req,
    input logic halt
);

    int error_count = 0;

    // one request at a time on the memory port
    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        !(mem_rd_req && mem_wr_req))
        else begin
            error_count++;
            $error("read and write strobes high in the same cycle");
        end

    a_quiet_when_halted: assert property (@(posedge clk) disable iff (rst)
        halt |-> !(mem_rd_req || mem_wr_req))
        else begin
            error_count++;
            $error("memory strobe issued while halted");
        end

    // only reset clears halt
    a_halt_sticky: assert property (@(posedge clk) disable iff (rst)
        halt |=> halt)
        else begin
            error_count++;
            $error("halt dropped without reset");
        end

endmodule

bind proc_core proc_core_assertions checks (
    .clk(clk), .rst(rst), .mem_rd_req(mem_rd_req), .mem_wr_req(mem_wr_req), .halt(halt)
);

//--- sim/proc_core_tb.sv
// Core testbench
`timescale 1ns/1ps

`include "proc_config.svh"

module proc_core_tb;

    localparam int MEM_WORDS  = 256;
    localparam int TIMEOUT    = 4000;
    localparam int OPC_IMM    = 'h13;
    localparam int OPC_LOAD   = 'h03;
    localparam int OPC_LUI    = 'h37;
    localparam int OPC_AUIPC  = 'h17;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] mem_addr;
    logic [31:0] mem_wr_data;
    logic        mem_rd_req;
    logic        mem_wr_req;
    logic [31:0] mem_rd_data = '0;
    logic        mem_ack = 1'b0;
    logic [31:0] out;
    logic        out_valid;
    logic        halt;
    logic [31:0] pc;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] prog[$];
    logic [31:0] expect_q[$];
    logic [31:0] seen[$];

    logic        busy = 1'b0;
    int          delay = 0;
    logic [31:0] req_addr = '0;

    proc_core UUT (
        .clk(clk), .rst(rst),
        .mem_addr(mem_addr), .mem_wr_data(mem_wr_data),
        .mem_rd_req(mem_rd_req), .mem_wr_req(mem_wr_req),
        .mem_rd_data(mem_rd_data), .mem_ack(mem_ack),
        .out(out), .out_valid(out_valid), .halt(halt), .pc(pc)
    );

    always #5 clk = ~clk;

    // memory model that loads the program while reset is high
    always @(negedge clk) begin
        int i;
        mem_ack = 1'b0;
        if (rst) begin
            busy = 1'b0;
            for (i = 0; i < MEM_WORDS; i++) begin
                mem[i] = (i < prog.size()) ? prog[i] : {16'hC0DE, i[15:0]};
            end
        end else if (busy) begin
            if (delay == 1) begin
                mem_ack     = 1'b1;
                mem_rd_data = mem[req_addr[9:2]];
                busy        = 1'b0;
            end else begin
                delay = delay - 1;
            end
        end else if (mem_rd_req || mem_wr_req) begin
            busy     = 1'b1;
            delay    = 1 + ($urandom % 3);
            req_addr = mem_addr;
            if (mem_wr_req) begin
                mem[mem_addr[9:2]] = mem_wr_data;
            end
        end
    end

    function automatic logic [31:0] i_type(int imm, int rs1, int f3, int rd, int op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] s_type(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(int imm20, int rd, int op);
        return {imm20[19:0], rd[4:0], op[6:0]};
    endfunction

    // sw rd to the output address
    task automatic show(input int rd);
        prog.push_back(s_type(`OUT_ADDR, rd, 0));
    endtask

    task automatic add_halt();
        prog.push_back(s_type(`HALT_ADDR, 0, 0));
    endtask

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // reset, run until halt, then compare the collected outputs
    task automatic run_program(input string name);
        int cycles;
        int i;
        @(negedge clk);
        rst = 1'b1;
        seen.delete();
        repeat (4) @(negedge clk);
        rst = 1'b0;
        cycles = 0;
        while (!halt) begin
            @(negedge clk);
            if (out_valid) seen.push_back(out);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("%s: halt never rose before the timeout", name);
                $display("TESTBENCH FAILED");
                $fatal(1, "timeout");
            end
        end
        // nothing may come out once halted
        repeat (8) begin
            @(negedge clk);
            if (out_valid) seen.push_back(out);
        end
        check(seen.size(), expect_q.size(), {name, " output count"});
        for (i = 0; i < expect_q.size(); i++) begin
            check(seen[i], expect_q[i], $sformatf("%s output %0d", name, i));
        end
    endtask

    task automatic imm_alu_test();
        logic [31:0] a;
        logic [31:0] b;
        int r;
        a = 32'hFFFF_FFEC;
        b = a + 32'd100;
        prog.delete();
        expect_q.delete();
        prog.push_back(i_type(-20, 0, 0, 1, OPC_IMM));
        prog.push_back(i_type(100, 1, 0, 2, OPC_IMM));
        prog.push_back(i_type('h5A5, 2, 4, 3, OPC_IMM));
        prog.push_back(i_type('h0F0, 1, 6, 4, OPC_IMM));
        prog.push_back(i_type('h07F, 1, 7, 5, OPC_IMM));
        prog.push_back(i_type(5, 1, 2, 6, OPC_IMM));
        prog.push_back(i_type(5, 1, 3, 7, OPC_IMM));
        prog.push_back(i_type(-1, 2, 3, 8, OPC_IMM));
        prog.push_back(i_type(3, 2, 1, 9, OPC_IMM));
        prog.push_back(i_type(4, 1, 5, 10, OPC_IMM));
        prog.push_back(i_type('h404, 1, 5, 11, OPC_IMM));
        for (r = 1; r <= 11; r++) show(r);
        add_halt();
        expect_q = '{a, b, b ^ 32'h5A5, a | 32'h0F0, a & 32'h07F,
                     {31'b0, $signed(a) < 32'sd5}, {31'b0, a < 32'd5},
                     {31'b0, b < 32'hFFFF_FFFF}, b << 3, a >> 4, $signed(a) >>> 4};
        run_program("immediate alu");
    endtask

    task automatic reg_alu_test();
        logic [31:0] va;
        logic [31:0] vb;
        logic [31:0] sra_v;
        int r;
        prog.delete();
        va = 32'hFFFF_8123;
        prog.push_back(u_type('hFFFF8, 1, OPC_LUI));
        prog.push_back(i_type('h123, 1, 0, 1, OPC_IMM));
        // auipc adds its own address
        vb = 32'(prog.size() * 4) + 32'h1000;
        prog.push_back(u_type(1, 2, OPC_AUIPC));
        prog.push_back(i_type(5, 0, 0, 3, OPC_IMM));
        prog.push_back(r_type(0, 2, 1, 0, 4));
        prog.push_back(r_type('h20, 2, 1, 0, 5));
        prog.push_back(r_type(0, 2, 1, 2, 6));
        prog.push_back(r_type(0, 2, 1, 3, 7));
        prog.push_back(r_type(0, 2, 1, 7, 8));
        prog.push_back(r_type(0, 2, 1, 6, 9));
        prog.push_back(r_type(0, 2, 1, 4, 10));
        prog.push_back(r_type(0, 3, 1, 1, 11));
        prog.push_back(r_type(0, 3, 1, 5, 12));
        prog.push_back(r_type('h20, 3, 1, 5, 13));
        prog.push_back(r_type(0, 2, 1, 0, 0));
        for (r = 0; r <= 13; r++) show(r);
        add_halt();
        sra_v = $signed(va) >>> 5;
        expect_q = '{32'd0, va, vb, 32'd5, va + vb, va - vb,
                     {31'b0, $signed(va) < $signed(vb)}, {31'b0, va < vb},
                     va & vb, va | vb, va ^ vb, va << 5, va >> 5, sra_v};
        run_program("register alu");
    endtask

    task automatic load_store_test();
        prog.delete();
        prog.push_back(u_type('h12345, 2, OPC_LUI));
        prog.push_back(i_type('h678, 2, 0, 2, OPC_IMM));
        prog.push_back(i_type(512, 0, 0, 1, OPC_IMM));
        prog.push_back(i_type(-99, 0, 0, 3, OPC_IMM));
        prog.push_back(s_type(0, 2, 1));
        prog.push_back(s_type(4, 3, 1));
        prog.push_back(s_type(-8, 3, 1));
        prog.push_back(i_type(4, 1, 2, 4, OPC_LOAD));
        prog.push_back(i_type(0, 1, 2, 5, OPC_LOAD));
        prog.push_back(i_type(-8, 1, 2, 6, OPC_LOAD));
        show(4);
        show(5);
        show(6);
        add_halt();
        expect_q = '{32'hFFFF_FF9D, 32'h1234_5678, 32'hFFFF_FF9D};
        run_program("load and store");
        check(mem[128], 32'h1234_5678, "memory word at 512");
        check(mem[129], 32'hFFFF_FF9D, "memory word at 516");
        check(mem[126], 32'hFFFF_FF9D, "memory word at 504");
    endtask

    // x10 ends as 1 when the branch skips the clearing addi
    task automatic branch_case(input int f3, input int rs1, input int rs2, input logic taken);
        prog.push_back(i_type(1, 0, 0, 10, OPC_IMM));
        prog.push_back(b_type(8, rs2, rs1, f3));
        prog.push_back(i_type(0, 0, 0, 10, OPC_IMM));
        show(10);
        expect_q.push_back({31'b0, taken});
    endtask

    task automatic branch_test();
        logic [31:0] va;
        logic [31:0] vb;
        va = 32'hFFFF_FFFB;
        vb = 32'd7;
        prog.delete();
        // countdown 3, 2, 1 with a backward bne
        prog.push_back(i_type(3, 0, 0, 1, OPC_IMM));
        show(1);
        prog.push_back(i_type(-1, 1, 0, 1, OPC_IMM));
        prog.push_back(b_type(-8, 0, 1, 1));
        expect_q = '{32'd3, 32'd2, 32'd1};
        prog.push_back(i_type(-5, 0, 0, 2, OPC_IMM));
        prog.push_back(i_type(7, 0, 0, 3, OPC_IMM));
        prog.push_back(i_type(-5, 0, 0, 4, OPC_IMM));
        branch_case(0, 2, 4, va == va);
        branch_case(0, 2, 3, va == vb);
        branch_case(1, 2, 3, va != vb);
        branch_case(1, 2, 4, va != va);
        branch_case(4, 2, 3, $signed(va) < $signed(vb));
        branch_case(4, 3, 2, $signed(vb) < $signed(va));
        branch_case(5, 3, 2, $signed(vb) >= $signed(va));
        branch_case(5, 2, 4, $signed(va) >= $signed(va));
        branch_case(5, 2, 3, $signed(va) >= $signed(vb));
        branch_case(6, 2, 3, va < vb);
        branch_case(6, 3, 2, vb < va);
        branch_case(7, 2, 3, va >= vb);
        branch_case(7, 3, 2, vb >= va);
        add_halt();
        run_program("branches");
    endtask

    task automatic halt_test();
        prog.delete();
        prog.push_back(i_type(11, 0, 0, 1, OPC_IMM));
        show(1);
        add_halt();
        prog.push_back(i_type(22, 0, 0, 1, OPC_IMM));
        show(1);
        add_halt();
        expect_q = '{32'd11};
        run_program("halt store");
        check(pc, 32'd8, "pc held at the halt store");

        prog.delete();
        prog.push_back(i_type(33, 0, 0, 1, OPC_IMM));
        show(1);
        // opcode 1111111 is not part of the instruction set
        prog.push_back(32'h0000_007F);
        prog.push_back(i_type(44, 0, 0, 1, OPC_IMM));
        show(1);
        add_halt();
        expect_q = '{32'd33};
        run_program("illegal opcode");
        check(pc, 32'd8, "pc held at the illegal word");
    endtask

    initial begin
        rst = 1'b1;
        void'($urandom(48));
        imm_alu_test();
        reg_alu_test();
        load_store_test();
        branch_test();
        halt_test();
        if (UUT.checks.error_count == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("protocol assertions failed during the run");
            $display("TESTBENCH FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

//--- verilog/exec_if.sv
// Execute result bus
`timescale 1ns/1ps

`include "proc_config.svh"

interface exec_if;

    logic [`DATA_WIDTH-1:0] result;
    logic                   reg_wr;
    logic                   branch_taken;
    logic [`ADDR_WIDTH-1:0] next_pc;
    logic [`ADDR_WIDTH-1:0] mem_addr;
    logic [`DATA_WIDTH-1:0] store_data;
    // store targets that never reach memory
    logic                   is_out_store;
    logic                   is_halt_store;

    modport exec (
        output result, reg_wr, branch_taken, next_pc,
        output mem_addr, store_data, is_out_store, is_halt_store
    );

    modport seq (
        input result, reg_wr, branch_taken, next_pc,
        input mem_addr, store_data, is_out_store, is_halt_store
    );

endinterface

//--- verilog/exec_unit.sv
// ALU and branch unit
`timescale 1ns/1ps

`include "proc_config.svh"

module exec_unit (
    input  proc_pkg::decoded_instr_t instr,
    input  logic [`ADDR_WIDTH-1:0]   pc,
    input  logic [`DATA_WIDTH-1:0]   rs1_data,
    input  logic [`DATA_WIDTH-1:0]   rs2_data,
    exec_if.exec                     ex
);
    import proc_pkg::*;

    logic [`DATA_WIDTH-1:0] op_b;
    logic [4:0]             shamt;
    logic                   lt_s;
    logic                   lt_u;
    logic                   eq;
    logic                   cond;
    logic [`DATA_WIDTH-1:0] alu_out;

    // branches have use_imm low, so op_b is rs2 for them too
    assign op_b  = instr.use_imm ? instr.imm : rs2_data;
    assign shamt = op_b[4:0];
    assign lt_s  = $signed(rs1_data) < $signed(op_b);
    assign lt_u  = rs1_data < op_b;
    assign eq    = rs1_data == op_b;

    always_comb begin
        case (instr.alu_op)
            ALU_ADD:    alu_out = rs1_data + op_b;
            ALU_SUB:    alu_out = rs1_data - op_b;
            ALU_SLT:    alu_out = {31'b0, lt_s};
            ALU_SLTU:   alu_out = {31'b0, lt_u};
            ALU_XOR:    alu_out = rs1_data ^ op_b;
            ALU_OR:     alu_out = rs1_data | op_b;
            ALU_AND:    alu_out = rs1_data & op_b;
            ALU_SLL:    alu_out = rs1_data << shamt;
            ALU_SRL:    alu_out = rs1_data >> shamt;
            ALU_SRA:    alu_out = $unsigned($signed(rs1_data) >>> shamt);
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    always_comb begin
        case (instr.branch_kind)
            BEQ:     cond = eq;
            BNE:     cond = !eq;
            BLT:     cond = lt_s;
            BGE:     cond = !lt_s;
            BLTU:    cond = lt_u;
            BGEU:    cond = !lt_u;
            default: cond = 1'b0;
        endcase
    end

    assign ex.result = (instr.opcode == AUIPC) ? pc + instr.imm : alu_out;
    assign ex.reg_wr = (instr.opcode == OPIMM) || (instr.opcode == OP) ||
                       (instr.opcode == LUI) || (instr.opcode == AUIPC);

    assign ex.branch_taken = (instr.opcode == BRANCH) && cond;
    assign ex.next_pc      = ex.branch_taken ? pc + instr.imm : pc + `ADDR_WIDTH'(4);

    // loads and stores share the rs1 + imm address
    assign ex.mem_addr   = rs1_data + instr.imm;
    assign ex.store_data = rs2_data;

    assign ex.is_out_store  = (instr.opcode == STORE) && (ex.mem_addr == `OUT_ADDR);
    assign ex.is_halt_store = (instr.opcode == STORE) && (ex.mem_addr == `HALT_ADDR);

endmodule

//--- verilog/instr_decode.sv
// Instruction decoder
`timescale 1ns/1ps

`include "proc_config.svh"

module instr_decode (
    input  logic [`INSTR_WIDTH-1:0] word,
    output proc_pkg::decoded_instr_t instr
);
    import proc_pkg::*;

    logic [6:0]             op_raw;
    logic [2:0]             funct3;
    logic [`DATA_WIDTH-1:0] i_imm;
    logic [`DATA_WIDTH-1:0] s_imm;
    logic [`DATA_WIDTH-1:0] b_imm;
    logic [`DATA_WIDTH-1:0] u_imm;

    assign op_raw = word[6:0];
    assign funct3 = word[14:12];

    assign i_imm = {{20{word[31]}}, word[31:20]};
    assign s_imm = {{20{word[31]}}, word[31:25], word[11:7]};
    assign b_imm = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
    assign u_imm = {word[31:12], 12'b0};

    always_comb begin
        instr.opcode      = opcode_e'(op_raw);
        instr.rd          = word[11:7];
        instr.rs1         = word[19:15];
        instr.rs2         = word[24:20];
        instr.branch_kind = branch_e'(funct3);
        instr.use_imm     = (op_raw == OPIMM) || (op_raw == LUI);
        instr.illegal     = 1'b0;
        instr.alu_op      = ALU_ADD;
        instr.imm         = i_imm;

        case (op_raw)
            OPIMM, OP: begin
                case (funct3)
                    // bit 30 only means SUB on the register form
                    3'b000: instr.alu_op = (op_raw == OP && word[30]) ? ALU_SUB : ALU_ADD;
                    3'b001: instr.alu_op = ALU_SLL;
                    3'b010: instr.alu_op = ALU_SLT;
                    3'b011: instr.alu_op = ALU_SLTU;
                    3'b100: instr.alu_op = ALU_XOR;
                    3'b101: instr.alu_op = word[30] ? ALU_SRA : ALU_SRL;
                    3'b110: instr.alu_op = ALU_OR;
                    default: instr.alu_op = ALU_AND;
                endcase
            end
            LUI: begin
                instr.alu_op = ALU_PASS_B;
                instr.imm    = u_imm;
            end
            AUIPC: instr.imm = u_imm;
            LOAD: instr.imm = i_imm;
            STORE: instr.imm = s_imm;
            BRANCH: begin
                instr.imm = b_imm;
                // funct3 010 and 011 are not branches
                instr.illegal = (funct3[2:1] == 2'b01);
            end
            default: instr.illegal = 1'b1;
        endcase
    end

endmodule

//--- verilog/proc_config.svh
// Core configuration
`ifndef PROC_CONFIG_SVH
`define PROC_CONFIG_SVH

// datapath widths
`define DATA_WIDTH 32
`define ADDR_WIDTH 32
`define INSTR_WIDTH 32

// register file shape
`define NUM_REGS 32
`define REG_SEL_WIDTH 5

// memory-mapped store targets
`define OUT_ADDR 32'd1000
`define HALT_ADDR 32'd1004

`endif

//--- verilog/proc_core.sv
// Integer processor core
`timescale 1ns/1ps

`include "proc_config.svh"

module proc_core (
    input  logic                   clk,
    input  logic                   rst,
    output logic [`ADDR_WIDTH-1:0] mem_addr,
    output logic [`DATA_WIDTH-1:0] mem_wr_data,
    output logic                   mem_rd_req,
    output logic                   mem_wr_req,
    input  logic [`DATA_WIDTH-1:0] mem_rd_data,
    input  logic                   mem_ack,
    output logic [`DATA_WIDTH-1:0] out,
    output logic                   out_valid,
    output logic                   halt,
    output logic [`ADDR_WIDTH-1:0] pc
);
    import proc_pkg::*;

    logic [`INSTR_WIDTH-1:0]   fetched_word;
    decoded_instr_t            dec_instr;
    logic [`DATA_WIDTH-1:0]    rs1_data;
    logic [`DATA_WIDTH-1:0]    rs2_data;
    logic                      wr_en;
    logic [`REG_SEL_WIDTH-1:0] wr_sel;
    logic [`DATA_WIDTH-1:0]    wr_data;

    exec_if ex_bus ();

    proc_sequencer u_seq (
        .clk(clk), .rst(rst), .mem_rd_data(mem_rd_data), .mem_ack(mem_ack),
        .instr(dec_instr), .ex(ex_bus.seq),
        .mem_addr(mem_addr), .mem_wr_data(mem_wr_data),
        .mem_rd_req(mem_rd_req), .mem_wr_req(mem_wr_req),
        .pc(pc), .fetched_word(fetched_word),
        .wr_en(wr_en), .wr_sel(wr_sel), .wr_data(wr_data),
        .out(out), .out_valid(out_valid), .halt(halt)
    );

    instr_decode u_decode (.word(fetched_word), .instr(dec_instr));

    reg_file u_regs (
        .clk(clk), .rst(rst), .rs1_sel(dec_instr.rs1), .rs2_sel(dec_instr.rs2),
        .wr_en(wr_en), .wr_sel(wr_sel), .wr_data(wr_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    exec_unit u_exec (
        .instr(dec_instr), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .ex(ex_bus.exec)
    );

endmodule

//--- verilog/proc_pkg.sv
// Core types
package proc_pkg;

    `include "proc_config.svh"

    // major opcodes, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        OPIMM  = 7'b0010011,
        OP     = 7'b0110011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    // branch funct3 codes
    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_e;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXEC,
        ST_MEM_WAIT,
        ST_HALTED
    } state_e;

    typedef struct packed {
        opcode_e                    opcode;
        logic [`REG_SEL_WIDTH-1:0]  rd;
        logic [`REG_SEL_WIDTH-1:0]  rs1;
        logic [`REG_SEL_WIDTH-1:0]  rs2;
        alu_op_e                    alu_op;
        branch_e                    branch_kind;
        logic                       use_imm;
        logic [`DATA_WIDTH-1:0]     imm;
        logic                       illegal;
    } decoded_instr_t;

endpackage

//--- verilog/proc_sequencer.sv
// Core sequencer
`timescale 1ns/1ps

`include "proc_config.svh"

module proc_sequencer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`DATA_WIDTH-1:0]    mem_rd_data,
    input  logic                      mem_ack,
    input  proc_pkg::decoded_instr_t  instr,
    exec_if.seq                       ex,
    output logic [`ADDR_WIDTH-1:0]    mem_addr,
    output logic [`DATA_WIDTH-1:0]    mem_wr_data,
    output logic                      mem_rd_req,
    output logic                      mem_wr_req,
    output logic [`ADDR_WIDTH-1:0]    pc,
    output logic [`INSTR_WIDTH-1:0]   fetched_word,
    output logic                      wr_en,
    output logic [`REG_SEL_WIDTH-1:0] wr_sel,
    output logic [`DATA_WIDTH-1:0]    wr_data,
    output logic [`DATA_WIDTH-1:0]    out,
    output logic                      out_valid,
    output logic                      halt
);
    import proc_pkg::*;

    state_e                    state;
    state_e                    state_n;
    logic [`ADDR_WIDTH-1:0]    pc_n;
    logic [`ADDR_WIDTH-1:0]    pc_plus4;
    logic [`ADDR_WIDTH-1:0]    addr_n;
    logic                      rd_req_n;
    logic                      wr_req_n;
    logic                      out_valid_n;
    logic                      pend_load;
    logic [`REG_SEL_WIDTH-1:0] pend_rd;

    assign pc_plus4     = pc + `ADDR_WIDTH'(4);
    assign fetched_word = (state == ST_EXEC) ? mem_rd_data : '0;
    assign halt         = (state == ST_HALTED);

    always_comb begin
        state_n     = state;
        pc_n        = pc;
        addr_n      = '0;
        rd_req_n    = 1'b0;
        wr_req_n    = 1'b0;
        out_valid_n = 1'b0;
        wr_en       = 1'b0;
        wr_sel      = instr.rd;
        wr_data     = ex.result;
        case (state)
            ST_FETCH: begin
                rd_req_n = 1'b1;
                addr_n   = pc;
                state_n  = ST_EXEC;
            end
            ST_EXEC: begin
                // the fetched word is only valid while mem_ack is high
                if (mem_ack) begin
                    if (instr.illegal || ex.is_halt_store) begin
                        state_n = ST_HALTED;
                    end else if (ex.is_out_store) begin
                        out_valid_n = 1'b1;
                        pc_n        = pc_plus4;
                        rd_req_n    = 1'b1;
                        addr_n      = pc_plus4;
                    end else if (instr.opcode == LOAD || instr.opcode == STORE) begin
                        rd_req_n = (instr.opcode == LOAD);
                        wr_req_n = (instr.opcode == STORE);
                        addr_n   = ex.mem_addr;
                        state_n  = ST_MEM_WAIT;
                    end else begin
                        wr_en    = ex.reg_wr;
                        pc_n     = ex.next_pc;
                        rd_req_n = 1'b1;
                        addr_n   = pc_n;
                    end
                end
            end
            ST_MEM_WAIT: begin
                if (mem_ack) begin
                    wr_en    = pend_load;
                    wr_sel   = pend_rd;
                    wr_data  = mem_rd_data;
                    pc_n     = pc_plus4;
                    rd_req_n = 1'b1;
                    addr_n   = pc_plus4;
                    state_n  = ST_EXEC;
                end
            end
            default: begin
                // halted until reset
                state_n = ST_HALTED;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_FETCH;
            pc         <= '0;
            mem_rd_req <= 1'b0;
            mem_wr_req <= 1'b0;
            out_valid  <= 1'b0;
            pend_load  <= 1'b0;
        end else begin
            state      <= state_n;
            pc         <= pc_n;
            mem_rd_req <= rd_req_n;
            mem_wr_req <= wr_req_n;
            out_valid  <= out_valid_n;
            if (state_n == ST_MEM_WAIT && state == ST_EXEC) begin
                pend_load <= (instr.opcode == LOAD);
            end
        end
    end

    // address, store data and output value
    always_ff @(posedge clk) begin
        if (rd_req_n || wr_req_n) begin
            mem_addr <= addr_n;
        end
        if (wr_req_n) begin
            mem_wr_data <= ex.store_data;
        end
        if (out_valid_n) begin
            out <= ex.store_data;
        end
        if (state_n == ST_MEM_WAIT && state == ST_EXEC) begin
            pend_rd <= instr.rd;
        end
    end

endmodule

//--- verilog/reg_file.sv
// Integer register file
`timescale 1ns/1ps

`include "proc_config.svh"

module reg_file (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`REG_SEL_WIDTH-1:0] rs1_sel,
    input  logic [`REG_SEL_WIDTH-1:0] rs2_sel,
    input  logic                      wr_en,
    input  logic [`REG_SEL_WIDTH-1:0] wr_sel,
    input  logic [`DATA_WIDTH-1:0]    wr_data,
    output logic [`DATA_WIDTH-1:0]    rs1_data,
    output logic [`DATA_WIDTH-1:0]    rs2_data
);

    logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_sel != '0) begin
            // x0 is never written, so it reads zero
            regs[wr_sel] <= wr_data;
        end
    end

    assign rs1_data = regs[rs1_sel];
    assign rs2_data = regs[rs2_sel];

endmodule
